//--- logic/wb_mem_pkg.sv
/* Single-word Wishbone B4 classic memory path. Widths, memory map and bank
   geometry are fixed here. RAM_LATENCY must be at least 2 */
`default_nettype none

package wb_mem_pkg;

  // ====================
  // Bus widths
  // ====================
  localparam int unsigned BYTE_W = 8;
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned SEL_W  = DATA_W / BYTE_W;

  // ====================
  // Bank geometry
  // ====================
  // 128-bit cache line, four words
  localparam int unsigned LINE_W         = 128;
  localparam int unsigned LINE_SEL_W     = LINE_W / BYTE_W;
  localparam int unsigned WORDS_PER_LINE = LINE_W / DATA_W;
  localparam int unsigned LINES_PER_BANK = 256;
  localparam int unsigned NUM_BANKS      = 4;
  localparam int unsigned RAM_LATENCY    = 4;

  // Address slicing inside one bank
  localparam int unsigned BYTE_OFS_W = $clog2(SEL_W);
  localparam int unsigned WORD_OFS_W = $clog2(WORDS_PER_LINE);
  localparam int unsigned LINE_OFS_W = $clog2(LINE_SEL_W);
  localparam int unsigned LINE_IDX_W = $clog2(LINES_PER_BANK);
  localparam int unsigned BANK_IDX_W = $clog2(NUM_BANKS);

  // ====================
  // Memory map
  // ====================
  // Each bank spans 4 KiB, banks packed back to back
  localparam int unsigned BANK_SPAN_LOG2 = 12;
  localparam logic [ADDR_W-1:0] MEM_BASE = 32'h8000_0000;
  localparam logic [ADDR_W-1:0] MEM_SIZE = ADDR_W'(NUM_BANKS) << BANK_SPAN_LOG2;
  // Exclusive upper bound of the window
  localparam logic [ADDR_W-1:0] MEM_END  = MEM_BASE + MEM_SIZE;

  // ====================
  // Payload structs
  // ====================
  // Host side request payload
  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [SEL_W-1:0]  sel;
  } host_req_t;

  // Wishbone master to slave
  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] adr;
    logic [DATA_W-1:0] dat;
    logic [SEL_W-1:0]  sel;
  } wb_req_t;

  // Wishbone slave to master
  typedef struct packed {
    logic [DATA_W-1:0] dat;
    logic              ack;
    logic              err;
  } wb_rsp_t;

endpackage

`default_nettype wire

//--- logic/wb_host_bridge.sv
/* One Wishbone classic cycle per four-phase host request, no bursts.
   The host must keep host_req_i stable while req_i is high */
`timescale 1ns/1ps
`default_nettype none

module wb_host_bridge (
  input  wire logic                          clk_i,
  input  wire logic                          rst_ni,
  input  wire logic                          req_i,
  input  wire wb_mem_pkg::host_req_t         host_req_i,
  output logic                               ack_o,
  output logic [wb_mem_pkg::DATA_W-1:0]      rdata_o,
  output logic                               err_o,
  output wb_mem_pkg::wb_req_t                wb_req_o,
  input  wire wb_mem_pkg::wb_rsp_t           wb_rsp_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUS,
    ST_HOLD
  } state_e;

  state_e                          state_q;
  logic                            bus_q;
  logic                            ack_q;
  wb_mem_pkg::host_req_t           host_q;
  logic [wb_mem_pkg::DATA_W-1:0]   rdata_q;
  logic                            err_q;
  logic                            start;
  logic                            done;

  // New request seen while idle
  assign start = (state_q == ST_IDLE) && req_i;
  // Slave terminated the cycle, either way
  assign done  = (state_q == ST_BUS) && (wb_rsp_i.ack || wb_rsp_i.err);

  // ====================
  // Control FSM
  // ====================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      bus_q   <= 1'b0;
      ack_q   <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (start) begin
            state_q <= ST_BUS;
            bus_q   <= 1'b1;
          end
        end
        ST_BUS: begin
          // Drop cyc/stb right after the termination
          if (done) begin
            state_q <= ST_HOLD;
            bus_q   <= 1'b0;
            ack_q   <= 1'b1;
          end
        end
        ST_HOLD: begin
          // Wait for the host to withdraw
          if (!req_i) begin
            state_q <= ST_IDLE;
            ack_q   <= 1'b0;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Payload capture
  always_ff @(posedge clk_i) begin
    if (start) begin
      host_q <= host_req_i;
    end
    if (done) begin
      // Writes return zero data
      rdata_q <= host_q.we ? '0 : wb_rsp_i.dat;
      err_q   <= wb_rsp_i.err;
    end
  end

  // cyc and stb move together, single access only
  assign wb_req_o = '{cyc: bus_q, stb: bus_q, we: host_q.we, adr: host_q.addr,
                      dat: host_q.wdata, sel: host_q.sel};

  assign ack_o   = ack_q;
  assign rdata_o = rdata_q;
  assign err_o   = err_q;

endmodule

`default_nettype wire

//--- logic/wb_addr_decoder.sv
/* Combinational decode of the RAM window into NUM_BANKS banks.
   Anything outside the window is terminated here with err */
`timescale 1ns/1ps
`default_nettype none

module wb_addr_decoder (
  input  wire wb_mem_pkg::wb_req_t  wb_req_i,
  output wb_mem_pkg::wb_req_t       bank_req_o [wb_mem_pkg::NUM_BANKS],
  output wb_mem_pkg::wb_rsp_t       unmapped_rsp_o
);

  logic                                 mapped;
  logic                                 bus_req;
  logic [wb_mem_pkg::BANK_IDX_W-1:0]    bank_idx;
  logic [wb_mem_pkg::NUM_BANKS-1:0]     bank_hit;

  // ====================
  // Window check
  // ====================
  // Half open range, base included and end excluded
  assign mapped = (wb_req_i.adr >= wb_mem_pkg::MEM_BASE) &&
                  (wb_req_i.adr <  wb_mem_pkg::MEM_END);

  assign bus_req = wb_req_i.cyc && wb_req_i.stb;

  // Bank index sits right above the 4 KiB bank span
  assign bank_idx = wb_req_i.adr[wb_mem_pkg::BANK_SPAN_LOG2 +: wb_mem_pkg::BANK_IDX_W];

  // One-hot bank select, empty when unmapped
  assign bank_hit = mapped ? (wb_mem_pkg::NUM_BANKS'(1) << bank_idx) : '0;

  // ====================
  // Request fan-out
  // ====================
  always_comb begin
    for (int b = 0; b < wb_mem_pkg::NUM_BANKS; b++) begin
      // Payload goes everywhere
      bank_req_o[b]     = wb_req_i;
      // Only the hit bank sees the cycle
      bank_req_o[b].cyc = wb_req_i.cyc && bank_hit[b];
      bank_req_o[b].stb = wb_req_i.stb && bank_hit[b];
    end
  end

  // Error termination for holes in the map
  // Held only while stb is up, so it lasts one cycle with this bridge
  always_comb begin
    unmapped_rsp_o     = '0;
    unmapped_rsp_o.err = bus_req && !mapped;
  end

endmodule

`default_nettype wire

//--- logic/wb_ram_bank.sv
/* Cache-line RAM bank for Wishbone classic single accesses, one read in flight.
   Writes ack in the strobe cycle, reads RAM_LATENCY cycles after acceptance */
`timescale 1ns/1ps
`default_nettype none

module wb_ram_bank (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire wb_mem_pkg::wb_req_t   wb_req_i,
  output wb_mem_pkg::wb_rsp_t        wb_rsp_o
);

  // ====================
  // Storage
  // ====================
  logic [wb_mem_pkg::LINE_W-1:0]      mem_q [wb_mem_pkg::LINES_PER_BANK];

  logic [wb_mem_pkg::LINE_W-1:0]      rd_line_q;
  logic [wb_mem_pkg::WORD_OFS_W-1:0]  rd_ofs_q;
  logic [wb_mem_pkg::RAM_LATENCY-1:0] delay_q;

  logic                               bus_req;
  logic                               read_busy;
  logic                               wr_en;
  logic                               rd_en;
  logic [wb_mem_pkg::LINE_IDX_W-1:0]  line_idx;
  logic [wb_mem_pkg::WORD_OFS_W-1:0]  word_ofs;
  logic [wb_mem_pkg::LINE_W-1:0]      wdata_exp;
  logic [wb_mem_pkg::LINE_SEL_W-1:0]  wstrb_exp;

  assign bus_req = wb_req_i.cyc && wb_req_i.stb;

  // Line address and word slot from the byte address
  assign line_idx = wb_req_i.adr[wb_mem_pkg::LINE_OFS_W +: wb_mem_pkg::LINE_IDX_W];
  assign word_ofs = wb_req_i.adr[wb_mem_pkg::BYTE_OFS_W +: wb_mem_pkg::WORD_OFS_W];

  // Classic cycle keeps stb high while the read is pending
  // so a strobe counts once until its ack has gone out
  assign read_busy = |delay_q;

  assign wr_en = bus_req && wb_req_i.we;
  assign rd_en = bus_req && !wb_req_i.we && !read_busy;

  // ====================
  // Write expansion
  // ====================
  // Word copied into every slot of the line
  assign wdata_exp = {wb_mem_pkg::WORDS_PER_LINE{wb_req_i.dat}};

  // Byte strobes land only on the addressed slot
  always_comb begin
    wstrb_exp = '0;
    if (wr_en) begin
      wstrb_exp = wb_mem_pkg::LINE_SEL_W'(wb_req_i.sel) << (word_ofs * wb_mem_pkg::SEL_W);
    end
  end

  // Byte-wise write, whole-line read
  always_ff @(posedge clk_i) begin
    for (int b = 0; b < wb_mem_pkg::LINE_SEL_W; b++) begin
      if (wstrb_exp[b]) begin
        mem_q[line_idx][b*wb_mem_pkg::BYTE_W +: wb_mem_pkg::BYTE_W] <=
          wdata_exp[b*wb_mem_pkg::BYTE_W +: wb_mem_pkg::BYTE_W];
      end
    end
    if (rd_en) begin
      rd_line_q <= mem_q[line_idx];
      // Slot kept for extraction at ack time
      rd_ofs_q  <= word_ofs;
    end
  end

  // ====================
  // Read latency
  // ====================
  // Pending bit walks the delay line, ack as it reaches the last stage
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      delay_q <= '0;
    end else begin
      delay_q <= {delay_q[wb_mem_pkg::RAM_LATENCY-2:0], rd_en};
    end
  end

  // Response
  always_comb begin
    wb_rsp_o     = '0;
    // Word pulled out of the registered line
    wb_rsp_o.dat = rd_line_q[rd_ofs_q*wb_mem_pkg::DATA_W +: wb_mem_pkg::DATA_W];
    // Write acks at once, read after the delay line
    wb_rsp_o.ack = wr_en || delay_q[wb_mem_pkg::RAM_LATENCY-1];
    // Bank never fails
    wb_rsp_o.err = 1'b0;
  end

endmodule

`default_nettype wire

//--- logic/wb_resp_mux.sv
/* AND-OR merge of slave responses. Relies on at most one source
   terminating per cycle */
`timescale 1ns/1ps
`default_nettype none

module wb_resp_mux (
  input  wire wb_mem_pkg::wb_rsp_t  bank_rsp_i [wb_mem_pkg::NUM_BANKS],
  input  wire wb_mem_pkg::wb_rsp_t  unmapped_rsp_i,
  output wb_mem_pkg::wb_rsp_t       wb_rsp_o
);

  always_comb begin
    wb_rsp_o = '0;

    // Banks
    for (int b = 0; b < wb_mem_pkg::NUM_BANKS; b++) begin
      wb_rsp_o.ack = wb_rsp_o.ack | bank_rsp_i[b].ack;
      wb_rsp_o.err = wb_rsp_o.err | bank_rsp_i[b].err;
      // Data only from a terminating source
      if (bank_rsp_i[b].ack || bank_rsp_i[b].err) begin
        wb_rsp_o.dat = wb_rsp_o.dat | bank_rsp_i[b].dat;
      end
    end

    // Error path for unmapped addresses
    wb_rsp_o.ack = wb_rsp_o.ack | unmapped_rsp_i.ack;
    wb_rsp_o.err = wb_rsp_o.err | unmapped_rsp_i.err;
    if (unmapped_rsp_i.ack || unmapped_rsp_i.err) begin
      wb_rsp_o.dat = wb_rsp_o.dat | unmapped_rsp_i.dat;
    end
  end

endmodule

`default_nettype wire

//--- logic/wb_ram_subsystem.sv
/* RAM subsystem top, host port to NUM_BANKS cache-line banks.
   Single accesses only, no stall or retry */
`timescale 1ns/1ps
`default_nettype none

module wb_ram_subsystem (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  input  wire logic                       req_i,
  input  wire wb_mem_pkg::host_req_t      host_req_i,
  output logic                            ack_o,
  output logic [wb_mem_pkg::DATA_W-1:0]   rdata_o,
  output logic                            err_o
);

  // Bridge side of the bus
  wb_mem_pkg::wb_req_t  bus_req;
  wb_mem_pkg::wb_rsp_t  bus_rsp;

  // Per-bank requests and responses
  wb_mem_pkg::wb_req_t  bank_req [wb_mem_pkg::NUM_BANKS];
  wb_mem_pkg::wb_rsp_t  bank_rsp [wb_mem_pkg::NUM_BANKS];
  wb_mem_pkg::wb_rsp_t  unmapped_rsp;

  // ====================
  // Host to Wishbone
  // ====================
  wb_host_bridge i_bridge (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req_i),
    .host_req_i (host_req_i),
    .ack_o      (ack_o),
    .rdata_o    (rdata_o),
    .err_o      (err_o),
    .wb_req_o   (bus_req),
    .wb_rsp_i   (bus_rsp)
  );

  wb_addr_decoder i_decoder (
    .wb_req_i       (bus_req),
    .bank_req_o     (bank_req),
    .unmapped_rsp_o (unmapped_rsp)
  );

  // ====================
  // RAM banks
  // ====================
  for (genvar b = 0; b < wb_mem_pkg::NUM_BANKS; b++) begin : gen_bank
    wb_ram_bank i_bank (
      .clk_i    (clk_i),
      .rst_ni   (rst_ni),
      .wb_req_i (bank_req[b]),
      .wb_rsp_o (bank_rsp[b])
    );
  end

  // Responses back to the bridge
  wb_resp_mux i_resp_mux (
    .bank_rsp_i     (bank_rsp),
    .unmapped_rsp_i (unmapped_rsp),
    .wb_rsp_o       (bus_rsp)
  );

endmodule

`default_nettype wire

//--- testbench/wb_ram_subsystem_assertions.sv
/* Host handshake and bank protocol checks, bound into the RAM subsystem top.
   Needs a simulator with concurrent assertion support */
`timescale 1ns/1ps
`default_nettype none

module wb_ram_subsystem_assertions (
  input wire logic                 clk_i,
  input wire logic                 rst_ni,
  input wire logic                 req_i,
  input wire logic                 ack_i,
  input wire wb_mem_pkg::wb_rsp_t  bank_rsp_i [wb_mem_pkg::NUM_BANKS]
);

  logic [wb_mem_pkg::NUM_BANKS-1:0] bank_ack;
  // One flag per rule
  bit   reset_fail  = 1'b0;
  bit   rise_fail   = 1'b0;
  bit   hold_fail   = 1'b0;
  bit   onehot_fail = 1'b0;
  logic any_fail;

  always_comb begin
    for (int b = 0; b < wb_mem_pkg::NUM_BANKS; b++) begin
      bank_ack[b] = bank_rsp_i[b].ack;
    end
  end

  assign any_fail = reset_fail | rise_fail | hold_fail | onehot_fail;

  // ====================
  // Host handshake
  // ====================
  // Quiet in reset and one cycle after
  reset_in_a: assert property (@(posedge clk_i) !rst_ni |-> !ack_i)
    else begin $error("ack_o high during reset"); reset_fail = 1'b1; end
  reset_out_a: assert property (@(posedge clk_i) !rst_ni |=> !ack_i)
    else begin $error("ack_o high right after reset"); reset_fail = 1'b1; end

  // Rise is caused by the request sampled on the edge that set ack
  ack_rise_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(ack_i) |-> $past(req_i))
    else begin $error("ack_o rose without req_i"); rise_fail = 1'b1; end

  // Four-phase return, ack held until req drops
  ack_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ack_i && req_i) |=> ack_i)
    else begin $error("ack_o fell while req_i high"); hold_fail = 1'b1; end

  // Bank side
  bank_ack_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(bank_ack))
    else begin $error("more than one bank ack"); onehot_fail = 1'b1; end

endmodule

bind wb_ram_subsystem wb_ram_subsystem_assertions assertions_inst (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .req_i      (req_i),
  .ack_i      (ack_o),
  .bank_rsp_i (bank_rsp)
);

`default_nettype wire

//--- testbench/wb_ram_subsystem_tb.sv
/* Host-side regression against a word model of the four banks. RAM is not cleared,
   so reads only target words that the model has already written */
`timescale 1ns/1ps
`default_nettype none

module wb_ram_subsystem_tb;

  localparam int unsigned TIMEOUT_CYCLES = 40;
  // Memory window, four banks of 4 KiB from 0x8000_0000
  localparam logic [31:0] WINDOW_BASE = 32'h8000_0000;
  localparam logic [31:0] WINDOW_END  = 32'h8000_4000;

  logic                          clk_i;
  logic                          rst_ni;
  logic                          req;
  wb_mem_pkg::host_req_t         host_req;
  logic                          ack;
  logic [wb_mem_pkg::DATA_W-1:0] rdata;
  logic                          err;

  // One word per 4 bytes of the window, flag set on first write
  logic [31:0] model_mem [4096];
  bit          written   [4096];
  integer      seed;
  // Extra cycles the host keeps req high after ack
  int unsigned hold_cycles;

  wb_ram_subsystem wb_ram_subsystem_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req),
    .host_req_i (host_req),
    .ack_o      (ack),
    .rdata_o    (rdata),
    .err_o      (err)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // ====================
  // Model helpers
  // ====================
  function automatic logic in_window(input logic [31:0] addr);
    return (addr >= WINDOW_BASE) && (addr < WINDOW_END);
  endfunction

  // Bank bits 13:12 plus word bits 11:2
  function automatic logic [11:0] word_idx(input logic [31:0] addr);
    return addr[13:2];
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  sel);
    logic [31:0] res;
    res = old_w;
    for (int i = 0; i < 4; i++) begin
      if (sel[i]) begin
        res[i*8 +: 8] = new_w[i*8 +: 8];
      end
    end
    return res;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  // Response must not move while the host still holds req
  task automatic check_held(input logic [31:0] rd, input logic rerr);
    assert (rdata === rd) else
      abort_run($sformatf("Error: rdata_o under back-pressure is %h, expected %h",
                          rdata, rd));
    assert (err === rerr) else
      abort_run($sformatf("Error: err_o under back-pressure is %h, expected %h",
                          err, rerr));
  endtask

  // ====================
  // Host transactions
  // ====================
  // Called on a falling edge, returns on a falling edge with ack low again
  task automatic host_access(input logic we, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [3:0] sel,
                             output logic [31:0] rd, output logic rerr);
    int unsigned cnt;
    host_req.we    = we;
    host_req.addr  = addr;
    host_req.wdata = wdata;
    host_req.sel   = sel;
    req            = 1'b1;
    cnt            = 0;
    while (!ack) begin
      @(negedge clk_i);
      cnt++;
      if (cnt > TIMEOUT_CYCLES) abort_run("Timeout waiting for ack_o to rise");
    end
    rd   = rdata;
    rerr = err;
    // Back-pressure from the host side
    for (int h = 0; h < hold_cycles; h++) begin
      @(negedge clk_i);
      check_held(rd, rerr);
    end
    req  = 1'b0;
    cnt  = 0;
    while (ack) begin
      @(negedge clk_i);
      cnt++;
      if (cnt > TIMEOUT_CYCLES) abort_run("Timeout waiting for ack_o to fall");
    end
  endtask

  task automatic check_err(input logic [31:0] addr, input logic got, input logic exp);
    assert (got === exp) else
      abort_run($sformatf("Error: err_o at %h is %h, expected %h", addr, got, exp));
  endtask

  task automatic check_rdata(input logic [31:0] addr, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else
      abort_run($sformatf("Error: rdata_o at %h is %h, expected %h", addr, got, exp));
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] sel);
    logic [31:0] rd;
    logic        rerr;
    logic [11:0] idx;
    idx = word_idx(addr);
    host_access(1'b1, addr, data, sel, rd, rerr);
    if (in_window(addr)) begin
      check_err(addr, rerr, 1'b0);
      model_mem[idx] = merge_bytes(model_mem[idx], data, sel);
      written[idx]   = 1'b1;
    end else begin
      // Unmapped, nothing in the model moves
      check_err(addr, rerr, 1'b1);
      check_rdata(addr, rd, '0);
    end
  endtask

  task automatic read_word(input logic [31:0] addr);
    logic [31:0] rd;
    logic        rerr;
    host_access(1'b0, addr, '0, 4'hF, rd, rerr);
    if (in_window(addr)) begin
      check_err(addr, rerr, 1'b0);
      check_rdata(addr, rd, model_mem[word_idx(addr)]);
    end else begin
      check_err(addr, rerr, 1'b1);
      check_rdata(addr, rd, '0);
    end
  endtask

  // Protocol checker status
  always @(negedge clk_i) begin
    if (wb_ram_subsystem_inst.assertions_inst.any_fail) begin
      abort_run("Bound protocol assertion failed");
    end
  end

  // ====================
  // Stimulus
  // ====================
  initial begin
    logic [31:0] rnd;
    logic [31:0] addr;
    logic [11:0] idx;
    seed        = 68;
    hold_cycles = 0;
    rst_ni      = 1'b0;
    req         = 1'b0;
    host_req    = '0;
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    // Full word round trip
    write_word(32'h8000_0010, 32'hDEAD_BEEF, 4'hF);
    read_word(32'h8000_0010);

    // Partial byte enables
    write_word(32'h8000_0124, 32'h1122_3344, 4'hF);
    write_word(32'h8000_0124, 32'hAABB_CCDD, 4'b0101);
    read_word(32'h8000_0124);
    write_word(32'h8000_0124, 32'h5566_7788, 4'b1000);
    read_word(32'h8000_0124);

    // Four slots of one line
    for (int w = 0; w < 4; w++) begin
      write_word(32'h8000_0200 + 32'(w * 4), 32'hC0DE_0000 + 32'(w), 4'hF);
    end
    for (int w = 0; w < 4; w++) begin
      read_word(32'h8000_0200 + 32'(w * 4));
    end

    // Same offset in every bank
    for (int b = 0; b < 4; b++) begin
      write_word(32'h8000_0040 + 32'(b) * 32'h1000, 32'hBA5E_0000 + 32'(b), 4'hF);
    end
    for (int b = 0; b < 4; b++) begin
      read_word(32'h8000_0040 + 32'(b) * 32'h1000);
    end

    // Outside the window, incl. aliases of bank 0 offset 0x40
    write_word(32'h7FFF_F040, 32'hFFFF_FFFF, 4'hF);
    write_word(32'h8000_4040, 32'hFFFF_FFFF, 4'hF);
    write_word(32'hFFFF_FFFC, 32'h0123_4567, 4'hF);
    read_word(32'h0000_0000);
    read_word(32'h8000_4000);
    read_word(32'h7FFF_FFFC);
    for (int b = 0; b < 4; b++) begin
      read_word(32'h8000_0040 + 32'(b) * 32'h1000);
    end

    // Random traffic over 16 words per bank
    for (int n = 0; n < 400; n++) begin
      rnd  = $random(seed);
      addr = WINDOW_BASE | (rnd & 32'h0000_303C);
      idx  = word_idx(addr);
      rnd  = $random(seed);
      hold_cycles = rnd[11:10];
      if (rnd[0] && written[idx]) begin
        read_word(addr);
      end else begin
        // First touch is a whole word so no byte stays unknown
        write_word(addr, $random(seed), written[idx] ? rnd[7:4] : 4'hF);
      end
      repeat (rnd[9:8]) @(negedge clk_i);
    end

    @(negedge clk_i);
    if (!wb_ram_subsystem_inst.assertions_inst.any_fail) begin
      $display("Regression passed");
      $finish;
    end else begin
      abort_run("Bound protocol assertion failed");
    end
  end

endmodule

`default_nettype wire

//--- wb_ram_subsystem.f
logic/wb_mem_pkg.sv
logic/wb_host_bridge.sv
logic/wb_addr_decoder.sv
logic/wb_ram_bank.sv
logic/wb_resp_mux.sv
logic/wb_ram_subsystem.sv
testbench/wb_ram_subsystem_assertions.sv
testbench/wb_ram_subsystem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the RAM subsystem regression with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log
rm -rf obj_dir

verilator --binary --timing --assert \
  --top-module wb_ram_subsystem_tb \
  -f wb_ram_subsystem.f \
  -o wb_ram_subsystem_sim

# Let the testbench see assertion errors before the run stops
./obj_dir/wb_ram_subsystem_sim +verilator+error+limit+100 > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Regression failed" "$LOG"; then
  exit 1
fi
grep -q "Regression passed" "$LOG"
